// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_muldiv
RTL_TOP   ?= muldiv_unit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
verilog/core_config_pkg.sv
verilog/muldiv_pkg.sv
verilog/srt.sv
verilog/booth.sv
verilog/muldiv_unit.sv
testbench/tb_muldiv.sv

// File: testbench/tb_muldiv.sv
`timescale 1ns/1ps

module tb_muldiv;

    import core_config_pkg::*;
    import muldiv_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int CYCLE_LIMIT = 40;
    localparam int OP_LATENCY  = ENGINE_LATENCY + 1;    // Output register adds a cycle
    localparam int DBZ_LATENCY = 3;
    localparam int N_RANDOM    = 50;
    localparam int NUM_OPS     = 8 * 25 + 8 * N_RANDOM + 2;
    localparam int WATCHDOG_NS = NUM_OPS * CYCLE_LIMIT * CLK_PERIOD + 2000;

    logic            clk;
    logic            rst_n;
    logic            start;
    muldiv_op_t      op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            valid;
    logic            busy;
    logic [XLEN-1:0] result;
    logic            div_by_zero;
    int              errors;
    // Zero, one, minus one, most negative, most positive
    logic [XLEN-1:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    muldiv_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    // M-extension rules evaluated on 64-bit operands
    function automatic logic [XLEN-1:0] model_result(input muldiv_op_t f,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] r;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        case (f)
            MUL:     r = sa * sb;
            MULH:    r = (sa * sb) >> XLEN;
            MULHSU:  r = (sa * {{XLEN{1'b0}}, b}) >> XLEN;
            MULHU:   r = ({{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b}) >> XLEN;
            DIV:     r = $signed(sa) / $signed(sb);       // Truncates toward zero
            DIVU:    r = {{XLEN{1'b0}}, a / b};
            REM:     r = $signed(sa) % $signed(sb);       // Sign of the dividend
            default: r = {{XLEN{1'b0}}, a % b};
        endcase
        if (f[2] && b == '0) begin
            r = f[1] ? {{XLEN{1'b0}}, a} : '1;            // Zero divisor
        end
        return r[XLEN-1:0];
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // With poke set a second start is pulsed while busy, and the held result is
    // then watched through idle cycles
    task automatic run_op(input muldiv_op_t f, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input bit poke);
        string tag;
        int    cycles;
        tag    = $sformatf("%s(%h, %h)", f.name(), a, b);
        op     = f;
        rs1    = a;
        rs2    = b;
        start  = 1'b1;
        cycles = 0;
        next_cycle();
        while (!valid && cycles < CYCLE_LIMIT) begin
            check_flag({"busy ", tag}, 1'b1, busy);
            start = poke && (cycles == 3);
            op    = poke ? MULHU : f;
            next_cycle();
            cycles++;
        end
        if (!valid) begin
            $display("No valid pulse from %s within %0d cycles", tag, CYCLE_LIMIT);
            errors++;
        end else begin
            check_result({"result ", tag}, model_result(f, a, b), result);
            check_flag({"div_by_zero ", tag}, f[2] && (b == '0), div_by_zero);
            check_flag({"busy at valid ", tag}, 1'b0, busy);
            check_result({"latency ", tag}, (f[2] && b == '0) ? DBZ_LATENCY : OP_LATENCY,
                         cycles);
        end
        repeat (poke ? CYCLE_LIMIT : 0) begin
            next_cycle();
            check_result({"held result ", tag}, model_result(f, a, b), result);
            check_flag({"valid while idle ", tag}, 1'b0, valid);
        end
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        errors = 0;
        rst_n  = 1'b0;
        start  = 1'b0;
        op     = MUL;
        rs1    = '0;
        rs2    = '0;
        void'($urandom(9));
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("valid after reset", 1'b0, valid);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("div_by_zero after reset", 1'b0, div_by_zero);
        check_result("result after reset", '0, result);

        // Corner pairs, a zero divisor takes the divide-by-zero path
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_op(muldiv_op_t'(k), corners[i], corners[j], 1'b0);
                end
            end
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            a = $urandom();
            b = $urandom() >> ($urandom() % XLEN);      // Divisors of every size
            for (int k = 0; k < 8; k++) begin
                run_op(muldiv_op_t'(k), a, b, 1'b0);
            end
        end

        run_op(DIV, 32'h8765_4321, 32'h0000_0123, 1'b1);
        run_op(MULH, 32'hdead_beef, 32'h1234_5678, 1'b1);

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog/booth.sv
`timescale 1ns/1ps

module booth (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               multiplicand_signed,
    input  logic                               multiplier_signed,
    input  logic [core_config_pkg::XLEN-1:0]   multiplicand,
    input  logic [core_config_pkg::XLEN-1:0]   multiplier,
    output logic                               valid,
    output logic [2*core_config_pkg::XLEN-1:0] product
);

    import core_config_pkg::*;
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        RUN    = 2'b01,
        FINISH = 2'b10
    } state_t;

    state_t                  state;
    state_t                  state_nxt;
    logic [ITER_COUNT_W-1:0] count;
    logic [ITER_COUNT_W-1:0] count_nxt;
    logic                    valid_nxt;

    logic [XLEN:0]           mcand;          // Extended multiplicand
    logic [2*XLEN+3:0]       acc;            // {A, Q, q-1}
    logic [XLEN+1:0]         acc_hi;
    logic [XLEN+1:0]         mcand_wide;
    logic [XLEN+1:0]         acc_sum;
    logic [2*XLEN+3:0]       acc_step;

    assign acc_hi     = acc[2*XLEN+3:XLEN+2];
    assign mcand_wide = {mcand[XLEN], mcand};

    // Radix-2 recoding on Q[0] and q-1
    always_comb begin
        case (acc[1:0])
            2'b01:   acc_sum = acc_hi + mcand_wide;
            2'b10:   acc_sum = acc_hi - mcand_wide;
            default: acc_sum = acc_hi;
        endcase
        acc_step = $signed({acc_sum, acc[XLEN+1:0]}) >>> 1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            count <= '0;
            valid <= 1'b0;
        end else begin
            state <= state_nxt;
            count <= count_nxt;
            valid <= valid_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        count_nxt = count;
        valid_nxt = 1'b0;

        case (state)
            IDLE: begin
                count_nxt = '0;
                if (start) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                count_nxt = count + 1'b1;
                if (count == ITER_COUNT_W'(ENGINE_LATENCY - 2)) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: begin
                valid_nxt = 1'b1;
                state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            mcand <= {multiplicand_signed & multiplicand[XLEN-1], multiplicand};
            acc   <= {{(XLEN+2){1'b0}}, multiplier_signed & multiplier[XLEN-1], multiplier, 1'b0};
        end else if (state == RUN) begin
            acc <= acc_step;
        end
        // Last step covers the extension bit of the multiplier
        if (state == FINISH) begin
            product <= acc_step[2*XLEN:1];
        end
    end

endmodule

// File: verilog/core_config_pkg.sv
package core_config_pkg;

    // Integer register width
    localparam int XLEN = 32;

endpackage

// File: verilog/muldiv_pkg.sv
package muldiv_pkg;

    // funct3 encodings of the M extension
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_t;

    localparam int ITER_COUNT_W   = 6;    // Engine step counters
    localparam int ENGINE_LATENCY = 33;   // Start edge to engine valid

endpackage

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  muldiv_pkg::muldiv_op_t           op,
    input  logic [core_config_pkg::XLEN-1:0] rs1,
    input  logic [core_config_pkg::XLEN-1:0] rs2,
    output logic                             valid,
    output logic                             busy,
    output logic [core_config_pkg::XLEN-1:0] result,
    output logic                             div_by_zero
);

    import core_config_pkg::*;
    import muldiv_pkg::*;

    muldiv_op_t        op_q;
    logic              accept;
    logic              is_div;
    logic              div_start;
    logic              mul_start;
    logic              div_signed;
    logic              mcand_signed;
    logic              mplier_signed;
    logic              div_valid;
    logic              mul_valid;
    logic              div_zero;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   result_sel;

    assign accept    = start && !busy;
    assign is_div    = op[2];                   // DIV, DIVU, REM, REMU
    assign div_start = accept && is_div;
    assign mul_start = accept && !is_div;

    assign div_signed    = (op == DIV) || (op == REM);
    assign mcand_signed  = (op != MULHU);
    assign mplier_signed = (op == MUL) || (op == MULH);

    srt u_div (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (div_start),
        .dividend_signed (div_signed),
        .divisor_signed  (div_signed),
        .dividend        (rs1),
        .divisor         (rs2),
        .valid           (div_valid),
        .quotient        (quotient),
        .remainder       (remainder),
        .div_by_zero     (div_zero)
    );

    booth u_mul (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (mul_start),
        .multiplicand_signed (mcand_signed),
        .multiplier_signed   (mplier_signed),
        .multiplicand        (rs1),
        .multiplier          (rs2),
        .valid               (mul_valid),
        .product             (product)
    );

    always_comb begin
        case (op_q)
            MUL:                 result_sel = product[XLEN-1:0];
            MULH, MULHSU, MULHU: result_sel = product[2*XLEN-1:XLEN];
            DIV, DIVU:           result_sel = quotient;
            default:             result_sel = remainder;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q        <= MUL;
            busy        <= 1'b0;
            valid       <= 1'b0;
            result      <= '0;
            div_by_zero <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (accept) begin
                op_q <= op;
                busy <= 1'b1;
            end
            if (div_valid || mul_valid) begin     // Only one engine runs at a time
                result      <= result_sel;
                div_by_zero <= div_valid && div_zero;
                valid       <= 1'b1;
                busy        <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/srt.sv
`timescale 1ns/1ps

module srt (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic                             dividend_signed,
    input  logic                             divisor_signed,
    input  logic [core_config_pkg::XLEN-1:0] dividend,
    input  logic [core_config_pkg::XLEN-1:0] divisor,
    output logic                             valid,
    output logic [core_config_pkg::XLEN-1:0] quotient,
    output logic [core_config_pkg::XLEN-1:0] remainder,
    output logic                             div_by_zero
);

    import core_config_pkg::*;
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        DIVIDE   = 2'b01,
        SIGN_FIX = 2'b10,
        ERR      = 2'b11
    } state_t;

    state_t                  state;
    state_t                  state_nxt;
    logic [2*XLEN:0]         aq;                 // Partial remainder : quotient
    logic [2*XLEN:0]         aq_nxt;
    logic [XLEN-1:0]         dvsr;               // Divisor magnitude
    logic [XLEN-1:0]         dvsr_nxt;
    logic [ITER_COUNT_W-1:0] count;
    logic [ITER_COUNT_W-1:0] count_nxt;
    logic                    valid_nxt;
    logic                    dbz_nxt;
    logic                    dividend_neg;
    logic                    dividend_neg_nxt;
    logic                    divisor_neg;
    logic                    divisor_neg_nxt;

    logic                    dividend_neg_in;
    logic                    divisor_neg_in;
    logic [XLEN-1:0]         dividend_mag;
    logic [XLEN-1:0]         divisor_mag;
    logic [2*XLEN:0]         aq_shift;
    logic [XLEN:0]           diff;
    logic                    neg_q;
    logic                    neg_r;
    logic [XLEN-1:0]         q_fixed;
    logic [XLEN-1:0]         r_fixed;

    assign dividend_neg_in = dividend_signed && dividend[XLEN-1];
    assign divisor_neg_in  = divisor_signed && divisor[XLEN-1];
    assign dividend_mag    = dividend_neg_in ? -dividend : dividend;
    assign divisor_mag     = divisor_neg_in ? -divisor : divisor;

    // Trial subtraction of the shifted partial remainder
    assign aq_shift = aq << 1;
    assign diff     = aq_shift[2*XLEN:XLEN] - {1'b0, dvsr};

    // Quotient sign follows the operand signs, remainder follows the dividend
    assign neg_q   = (dividend_neg ^ divisor_neg) && (aq[XLEN-1:0] != '0);
    assign neg_r   = dividend_neg && (aq[2*XLEN-1:XLEN] != '0);
    assign q_fixed = neg_q ? -aq[XLEN-1:0] : aq[XLEN-1:0];
    assign r_fixed = neg_r ? -aq[2*XLEN-1:XLEN] : aq[2*XLEN-1:XLEN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            count        <= '0;
            valid        <= 1'b0;
            div_by_zero  <= 1'b0;
            dividend_neg <= 1'b0;
            divisor_neg  <= 1'b0;
        end else begin
            state        <= state_nxt;
            count        <= count_nxt;
            valid        <= valid_nxt;
            div_by_zero  <= dbz_nxt;
            dividend_neg <= dividend_neg_nxt;
            divisor_neg  <= divisor_neg_nxt;
        end
    end

    always_ff @(posedge clk) begin
        aq   <= aq_nxt;
        dvsr <= dvsr_nxt;
    end

    always_comb begin
        state_nxt        = state;
        aq_nxt           = aq;
        dvsr_nxt         = dvsr;
        count_nxt        = count;
        valid_nxt        = 1'b0;
        dbz_nxt          = div_by_zero;
        dividend_neg_nxt = dividend_neg;
        divisor_neg_nxt  = divisor_neg;

        case (state)
            IDLE: begin
                count_nxt = '0;
                if (start) begin
                    dividend_neg_nxt = dividend_neg_in;
                    divisor_neg_nxt  = divisor_neg_in;
                    if (divisor == '0) begin
                        dbz_nxt   = 1'b1;
                        aq_nxt    = {1'b0, dividend, {XLEN{1'b1}}};  // Remainder keeps the dividend
                        state_nxt = ERR;
                    end else begin
                        dbz_nxt   = 1'b0;
                        aq_nxt    = {{(XLEN+1){1'b0}}, dividend_mag};
                        dvsr_nxt  = divisor_mag;
                        state_nxt = DIVIDE;
                    end
                end
            end

            DIVIDE: begin
                if (diff[XLEN]) begin
                    aq_nxt = aq_shift;                              // Restore, quotient bit 0
                end else begin
                    aq_nxt = {diff, aq_shift[XLEN-1:1], 1'b1};
                end
                count_nxt = count + 1'b1;
                if (count == ITER_COUNT_W'(XLEN - 1)) begin
                    state_nxt = SIGN_FIX;
                end
            end

            SIGN_FIX: begin
                aq_nxt    = {1'b0, r_fixed, q_fixed};
                valid_nxt = 1'b1;
                state_nxt = IDLE;
            end

            ERR: begin
                count_nxt = count + 1'b1;
                if (count != '0) begin                          // Second ERR cycle
                    valid_nxt = 1'b1;
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    assign quotient  = aq[XLEN-1:0];
    assign remainder = aq[2*XLEN-1:XLEN];

endmodule
